/* dv/rvCoreTb.sv */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvCoreTb;
    import rvPkg::*;

    localparam int clkPeriod  = 8;
    localparam int numRows    = 33;
    localparam int idleCycles = 16;
    localparam int loadCycles = `IMEM_WORDS + 4;
    // eight cycles per table row leaves room for every stall and flush
    localparam int watchdogCycles = 2 + 2 * idleCycles + loadCycles + numRows * 8;

    // event kinds of a table row
    localparam int evNone   = 0;
    localparam int evRetire = 1;
    localparam int evStore  = 2;

    logic                           clk;
    logic                           rstN;
    logic                           imemWe;
    logic [$clog2(`IMEM_WORDS)-1:0] imemAddr;
    wordT                           imemData;
    logic                           retireValid;
    regIdxT                         retireRd;
    wordT                           retireData;
    logic                           storeValid;
    wordT                           storeAddr;
    wordT                           storeData;

    // program table, one row per instruction word
    wordT   tableWord [numRows];
    int     tableKind [numRows];
    regIdxT tableRd [numRows];
    wordT   tableAddr [numRows];
    wordT   tableData [numRows];
    int     rowCount;

    // rows that produce a pulse, in program order
    int evRow [$];
    int evIdx;
    int valueErrors;
    int eventErrors;

    rvCore rvCore_inst (.*);

    bind rvCore rvCoreAsserts assertsInst (
        .clk         (clk),
        .rstN        (rstN),
        .stallFetch  (stallFetch),
        .flushDecode (flushDecode),
        .validDecode (validDecode),
        .validExec   (validExec),
        .pcDecode    (pcDecode)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    // RV32I encodings
    function automatic wordT rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
                                       input regIdxT rd, input regIdxT rs1, input regIdxT rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic wordT addiWord(input regIdxT rd, input regIdxT rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic wordT lwWord(input regIdxT rd, input regIdxT rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic wordT swWord(input regIdxT rs2, input regIdxT rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic wordT beqWord(input regIdxT rs1, input regIdxT rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic addRow(input wordT word, input int kind, input regIdxT rd,
                          input wordT addr, input wordT data);
        tableWord[rowCount] = word;
        tableKind[rowCount] = kind;
        tableRd[rowCount]   = rd;
        tableAddr[rowCount] = addr;
        tableData[rowCount] = data;
        rowCount++;
    endtask

    // expected values follow the ISA, written out by hand
    task automatic buildTable();
        rowCount = 0;
        // independent alu work
        addRow(addiWord(1, 0, 12'd5), evRetire, 1, 0, 32'h0000_0005);
        addRow(addiWord(2, 0, 12'd12), evRetire, 2, 0, 32'h0000_000C);
        addRow(addiWord(3, 0, 12'hFFD), evRetire, 3, 0, 32'hFFFF_FFFD);
        addRow(addiWord(4, 0, 12'h0F0), evRetire, 4, 0, 32'h0000_00F0);
        addRow(rTypeWord(7'h00, 3'b000, 5, 1, 2), evRetire, 5, 0, 32'h0000_0011);
        addRow(rTypeWord(7'h20, 3'b000, 6, 2, 1), evRetire, 6, 0, 32'h0000_0007);
        addRow(rTypeWord(7'h00, 3'b111, 7, 3, 4), evRetire, 7, 0, 32'h0000_00F0);
        addRow(rTypeWord(7'h00, 3'b110, 8, 1, 4), evRetire, 8, 0, 32'h0000_00F5);
        // raw chains at distance 1 and 2
        addRow(addiWord(9, 0, 12'd1), evRetire, 9, 0, 32'h0000_0001);
        addRow(rTypeWord(7'h00, 3'b000, 10, 9, 9), evRetire, 10, 0, 32'h0000_0002);
        addRow(addiWord(11, 0, 12'd3), evRetire, 11, 0, 32'h0000_0003);
        addRow(rTypeWord(7'h00, 3'b000, 12, 10, 0), evRetire, 12, 0, 32'h0000_0002);
        addRow(rTypeWord(7'h20, 3'b000, 13, 12, 11), evRetire, 13, 0, 32'hFFFF_FFFF);
        // distance 3 hits the same-cycle register bypass
        addRow(addiWord(14, 0, 12'd7), evRetire, 14, 0, 32'h0000_0007);
        addRow(addiWord(15, 0, 12'd9), evRetire, 15, 0, 32'h0000_0009);
        addRow(addiWord(16, 0, 12'd11), evRetire, 16, 0, 32'h0000_000B);
        addRow(rTypeWord(7'h00, 3'b110, 17, 14, 0), evRetire, 17, 0, 32'h0000_0007);
        // x0 write is dropped, x0 still reads zero
        addRow(addiWord(0, 0, 12'd99), evNone, 0, 0, 0);
        addRow(rTypeWord(7'h00, 3'b000, 18, 0, 1), evRetire, 18, 0, 32'h0000_0005);
        // store then dependent load and load-use
        addRow(addiWord(19, 0, 12'h040), evRetire, 19, 0, 32'h0000_0040);
        addRow(swWord(13, 19, 12'd8), evStore, 0, 32'h0000_0048, 32'hFFFF_FFFF);
        addRow(lwWord(20, 19, 12'd8), evRetire, 20, 0, 32'hFFFF_FFFF);
        addRow(rTypeWord(7'h00, 3'b000, 21, 20, 1), evRetire, 21, 0, 32'h0000_0004);
        addRow(swWord(21, 19, 12'd0), evStore, 0, 32'h0000_0040, 32'h0000_0004);
        // not taken, both followers retire
        addRow(beqWord(1, 2, 13'd12), evNone, 0, 0, 0);
        addRow(addiWord(22, 0, 12'h022), evRetire, 22, 0, 32'h0000_0022);
        addRow(addiWord(23, 0, 12'h023), evRetire, 23, 0, 32'h0000_0023);
        // taken, lands on row 30
        addRow(beqWord(18, 1, 13'd12), evNone, 0, 0, 0);
        addRow(addiWord(24, 0, 12'h055), evNone, 0, 0, 0);
        addRow(addiWord(25, 0, 12'h066), evNone, 0, 0, 0);
        addRow(addiWord(26, 0, 12'h077), evRetire, 26, 0, 32'h0000_0077);
        addRow(rTypeWord(7'h00, 3'b000, 27, 26, 22), evRetire, 27, 0, 32'h0000_0099);
        // halt, beq to itself
        addRow(beqWord(0, 0, 13'd0), evNone, 0, 0, 0);
    endtask

    task automatic retireSeen();
        int row;
        if (evIdx >= evRow.size()) begin
            eventErrors++;
            $display("extra retire of x%0d after the last expected event", retireRd);
        end else begin
            row = evRow[evIdx];
            if (tableKind[row] != evRetire) begin
                eventErrors++;
                $display("retire of x%0d seen where the store of row %0d was due",
                         retireRd, row);
            end else begin
                if (retireRd !== tableRd[row]) begin
                    valueErrors++;
                    $display("FAIL retireRd row %0d expected %h got %h",
                             row, tableRd[row], retireRd);
                end
                if (retireData !== tableData[row]) begin
                    valueErrors++;
                    $display("FAIL retireData row %0d expected %h got %h",
                             row, tableData[row], retireData);
                end
            end
            evIdx++;
        end
    endtask

    task automatic storeSeen();
        int row;
        if (evIdx >= evRow.size()) begin
            eventErrors++;
            $display("extra store to %h after the last expected event", storeAddr);
        end else begin
            row = evRow[evIdx];
            if (tableKind[row] != evStore) begin
                eventErrors++;
                $display("store seen where the retire of row %0d was due", row);
            end else begin
                if (storeAddr !== tableAddr[row]) begin
                    valueErrors++;
                    $display("FAIL storeAddr row %0d expected %h got %h",
                             row, tableAddr[row], storeAddr);
                end
                if (storeData !== tableData[row]) begin
                    valueErrors++;
                    $display("FAIL storeData row %0d expected %h got %h",
                             row, tableData[row], storeData);
                end
            end
            evIdx++;
        end
    endtask

    // writeback is older than memory, so the retire goes first
    task automatic watchPulses();
        if (retireValid === 1'b1) begin
            retireSeen();
        end
        if (storeValid === 1'b1) begin
            storeSeen();
        end
    endtask

    task automatic printCounts();
        $display("errors: %0d value, %0d event", valueErrors, eventErrors);
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        eventErrors++;
        $display("timeout with %0d of %0d expected events seen", evIdx, evRow.size());
        printCounts();
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rstN        = 1'b0;
        imemWe      = 1'b0;
        imemAddr    = '0;
        imemData    = '0;
        valueErrors = 0;
        eventErrors = 0;
        evIdx       = 0;
        buildTable();
        for (int r = 0; r < numRows; r++) begin
            if (tableKind[r] != evNone) begin
                evRow.push_back(r);
            end
        end

        // no program loaded, nothing may retire or store
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        repeat (idleCycles) begin
            @(negedge clk);
            if (retireValid !== 1'b0) begin
                valueErrors++;
                $display("FAIL retireValid expected 0 got %h", retireValid);
            end
            if (storeValid !== 1'b0) begin
                valueErrors++;
                $display("FAIL storeValid expected 0 got %h", storeValid);
            end
        end

        // load under reset, unused words get addi x0 with their own address
        rstN = 1'b0;
        for (int a = 0; a < `IMEM_WORDS; a++) begin
            imemWe   = 1'b1;
            imemAddr = a[$clog2(`IMEM_WORDS)-1:0];
            imemData = (a < numRows) ? tableWord[a] : addiWord(0, 0, a[11:0]);
            @(negedge clk);
        end
        imemWe = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        while (evIdx < evRow.size()) begin
            @(negedge clk);
            watchPulses();
        end
        // the halt loop must stay silent
        repeat (idleCycles) begin
            @(negedge clk);
            watchPulses();
        end

        printCounts();
        if ((valueErrors == 0) && (eventErrors == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* dv/rvCore_asserts.sv */
`timescale 1ns/100ps

module rvCoreAsserts (
    input logic           clk,
    input logic           rstN,
    input logic           stallFetch,
    input logic           flushDecode,
    input logic           validDecode,
    input logic           validExec,
    input rvPkg::wordT    pcDecode
);

    // a stalled fetch keeps the decode slot and its pc in place
    stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
        stallFetch |=> $stable(pcDecode))
        else $error("decode pc moved across a stall");

    // a taken beq leaves bubbles in decode and execute
    flushLeavesBubbles: assert property (@(posedge clk) disable iff (!rstN)
        flushDecode |=> (!validDecode && !validExec))
        else $error("decode or execute slot still valid after a flush");

    // producer leaves memory within two cycles, bubbles fill execute meanwhile
    stallAtMostTwo: assert property (@(posedge clk) disable iff (!rstN)
        (stallFetch ##1 stallFetch) |=> !stallFetch)
        else $error("stall lasted longer than two cycles");

endmodule

/* rvPipe.f */
+incdir+source
source/rvPkg.sv
source/fetchUnit.sv
source/regFile.sv
source/decodeUnit.sv
source/hazardDetect.sv
source/executeUnit.sv
source/memWriteback.sv
source/rvCore.sv
dv/rvCore_asserts.sv
dv/rvCoreTb.sv

/* source/decodeUnit.sv */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module decodeUnit (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::wordT   pcDecode,
    input  rvPkg::wordT   instrDecode,
    input  logic          validDecode,
    input  rvPkg::wordT   readData1,
    input  rvPkg::wordT   readData2,
    input  logic          stallDecode,
    input  logic          flushExec,
    output rvPkg::regIdxT sourceReg1Dec,
    output rvPkg::regIdxT sourceReg2Dec,
    output rvPkg::wordT   pcExec,
    output rvPkg::wordT   operandAExec,
    output rvPkg::wordT   operandBExec,
    output rvPkg::wordT   immExec,
    output rvPkg::aluOpE  aluOpExec,
    output logic          useImmExec,
    output rvPkg::regIdxT destRegExec,
    output logic          loadExec,
    output logic          storeExec,
    output logic          branchExec,
    output logic          validExec
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regIdxT     rd;
    regIdxT     rs1;
    regIdxT     rs2;
    wordT       immI;
    wordT       immS;
    wordT       immB;

    // raw decode of the instruction word
    logic   legal;
    logic   useRs1;
    logic   useRs2;
    logic   hasDest;
    logic   useImmDec;
    logic   loadDec;
    logic   storeDec;
    logic   branchDec;
    wordT   immDec;
    aluOpE  aluOpDec;

    // qualified by the slot valid bit
    logic   validDec;
    regIdxT destDec;

    assign opcode = instrDecode[6:0];
    assign rd     = instrDecode[11:7];
    assign funct3 = instrDecode[14:12];
    assign rs1    = instrDecode[19:15];
    assign rs2    = instrDecode[24:20];
    assign funct7 = instrDecode[31:25];

    // sign-extended immediates
    assign immI = {{(`XLEN-12){instrDecode[31]}}, instrDecode[31:20]};
    assign immS = {{(`XLEN-12){instrDecode[31]}}, instrDecode[31:25], instrDecode[11:7]};
    assign immB = {{(`XLEN-13){instrDecode[31]}}, instrDecode[31], instrDecode[7],
                   instrDecode[30:25], instrDecode[11:8], 1'b0};

    always_comb begin
        legal     = 1'b0;
        useRs1    = 1'b0;
        useRs2    = 1'b0;
        hasDest   = 1'b0;
        useImmDec = 1'b0;
        loadDec   = 1'b0;
        storeDec  = 1'b0;
        branchDec = 1'b0;
        immDec    = immI;
        aluOpDec  = aluPassB;
        case (opcode)
            opReg: begin
                useRs1  = 1'b1;
                useRs2  = 1'b1;
                hasDest = 1'b1;
                case (funct3)
                    // add or sub, funct7 bit 5 selects sub
                    3'b000: begin
                        legal    = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                        aluOpDec = funct7[5] ? aluSub : aluAdd;
                    end
                    3'b110: begin
                        legal    = (funct7 == 7'b0000000);
                        aluOpDec = aluOr;
                    end
                    3'b111: begin
                        legal    = (funct7 == 7'b0000000);
                        aluOpDec = aluAnd;
                    end
                    default: legal = 1'b0;
                endcase
            end
            opImm: begin
                // addi only
                legal     = (funct3 == 3'b000);
                useRs1    = 1'b1;
                hasDest   = 1'b1;
                useImmDec = 1'b1;
                aluOpDec  = aluAdd;
            end
            opLoad: begin
                // lw only
                legal     = (funct3 == 3'b010);
                useRs1    = 1'b1;
                hasDest   = 1'b1;
                useImmDec = 1'b1;
                loadDec   = 1'b1;
                aluOpDec  = aluAdd;
            end
            opStore: begin
                legal     = (funct3 == 3'b010);
                useRs1    = 1'b1;
                useRs2    = 1'b1;
                useImmDec = 1'b1;
                storeDec  = 1'b1;
                immDec    = immS;
                aluOpDec  = aluAdd;
            end
            opBranch: begin
                // beq only, compare done on raw operands in execute
                legal     = (funct3 == 3'b000);
                useRs1    = 1'b1;
                useRs2    = 1'b1;
                branchDec = 1'b1;
                immDec    = immB;
            end
            default: legal = 1'b0;
        endcase
    end

    assign validDec = validDecode && legal;

    // unused sources read as x0 so they never raise a stall
    assign sourceReg1Dec = (validDec && useRs1) ? rs1 : '0;
    assign sourceReg2Dec = (validDec && useRs2) ? rs2 : '0;

    // sw, beq and dead slots carry destination 0
    assign destDec = (validDec && hasDest) ? rd : '0;

    // execute register control, a stall or flush inserts a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validExec   <= 1'b0;
            destRegExec <= '0;
            loadExec    <= 1'b0;
            storeExec   <= 1'b0;
            branchExec  <= 1'b0;
        end else if (stallDecode || flushExec) begin
            validExec   <= 1'b0;
            destRegExec <= '0;
            loadExec    <= 1'b0;
            storeExec   <= 1'b0;
            branchExec  <= 1'b0;
        end else begin
            validExec   <= validDec;
            destRegExec <= destDec;
            loadExec    <= validDec && loadDec;
            storeExec   <= validDec && storeDec;
            branchExec  <= validDec && branchDec;
        end
    end

    // payload only matters while validExec is set
    always_ff @(posedge clk) begin
        pcExec       <= pcDecode;
        operandAExec <= readData1;
        operandBExec <= readData2;
        immExec      <= immDec;
        aluOpExec    <= aluOpDec;
        useImmExec   <= useImmDec;
    end

endmodule

/* source/executeUnit.sv */
`timescale 1ns/100ps

module executeUnit (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::wordT   pcExec,
    input  rvPkg::wordT   operandAExec,
    input  rvPkg::wordT   operandBExec,
    input  rvPkg::wordT   immExec,
    input  rvPkg::aluOpE  aluOpExec,
    input  logic          useImmExec,
    input  rvPkg::regIdxT destRegExec,
    input  logic          loadExec,
    input  logic          storeExec,
    input  logic          branchExec,
    input  logic          validExec,
    output logic          pcSrcExec,
    output rvPkg::wordT   branchTarget,
    output rvPkg::wordT   aluResultMem,
    output rvPkg::wordT   storeDataMem,
    output rvPkg::regIdxT destRegMem,
    output logic          loadMem,
    output logic          storeMem,
    output logic          validMem
);
    import rvPkg::*;

    wordT aluB;
    wordT aluResult;

    // immediate for addi, lw and sw
    assign aluB = useImmExec ? immExec : operandBExec;

    always_comb begin
        case (aluOpExec)
            aluAdd:   aluResult = operandAExec + aluB;
            aluSub:   aluResult = operandAExec - aluB;
            aluAnd:   aluResult = operandAExec & aluB;
            aluOr:    aluResult = operandAExec | aluB;
            default:  aluResult = aluB;
        endcase
    end

    // beq target is pc relative
    assign branchTarget = pcExec + immExec;
    assign pcSrcExec    = validExec && branchExec && (operandAExec == operandBExec);

    // memory register control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validMem   <= 1'b0;
            destRegMem <= '0;
            loadMem    <= 1'b0;
            storeMem   <= 1'b0;
        end else begin
            validMem   <= validExec;
            destRegMem <= destRegExec;
            loadMem    <= loadExec;
            storeMem   <= storeExec;
        end
    end

    // result or address, plus store data from rs2
    always_ff @(posedge clk) begin
        aluResultMem <= aluResult;
        storeDataMem <= operandBExec;
    end

endmodule

/* source/fetchUnit.sv */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module fetchUnit (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           imemWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr,
    input  rvPkg::wordT                    imemData,
    input  logic                           stallFetch,
    input  logic                           stallDecode,
    input  logic                           flushDecode,
    input  logic                           pcSrcExec,
    input  rvPkg::wordT                    branchTarget,
    output rvPkg::wordT                    pcDecode,
    output rvPkg::wordT                    instrDecode,
    output logic                           validDecode
);
    import rvPkg::*;

    localparam int imemAddrW = $clog2(`IMEM_WORDS);

    // addi x0, x0, 0
    localparam wordT nopInstr = 32'h0000_0013;

    wordT imem [`IMEM_WORDS];
    wordT pc;
    wordT pcNext;
    wordT instrFetch;

    // program load port, one word per cycle
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    // word addressed, low two pc bits ignored
    assign instrFetch = imem[pc[imemAddrW+1:2]];

    // taken branch wins over a stall
    always_comb begin
        if (pcSrcExec) begin
            pcNext = branchTarget;
        end else if (stallFetch) begin
            pcNext = pc;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // decode register valid bit
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validDecode <= 1'b0;
        end else if (flushDecode) begin
            validDecode <= 1'b0;
        end else if (!stallDecode) begin
            validDecode <= 1'b1;
        end
    end

    // decode register payload, a flush leaves a nop behind
    always_ff @(posedge clk) begin
        if (flushDecode) begin
            instrDecode <= nopInstr;
        end else if (!stallDecode) begin
            instrDecode <= instrFetch;
            pcDecode    <= pc;
        end
    end

endmodule

/* source/hazardDetect.sv */
`timescale 1ns/100ps

module hazardDetect (
    input  rvPkg::regIdxT sourceReg1Dec,
    input  rvPkg::regIdxT sourceReg2Dec,
    input  rvPkg::regIdxT destRegExec,
    input  rvPkg::regIdxT destRegMem,
    input  logic          loadExec,
    input  logic          pcSrcExec,
    output logic          stallFetch,
    output logic          stallDecode,
    output logic          flushDecode,
    output logic          flushExec
);

    logic src1Hazard;
    logic src2Hazard;
    logic rawHazard;
    logic loadUseStall;
    logic stall;

    // no forwarding, so any pending write to a live source stalls
    // x0 is checked per source, destination 0 means no write
    assign src1Hazard = (sourceReg1Dec != '0) &&
                        ((sourceReg1Dec == destRegExec) || (sourceReg1Dec == destRegMem));
    assign src2Hazard = (sourceReg2Dec != '0) &&
                        ((sourceReg2Dec == destRegExec) || (sourceReg2Dec == destRegMem));
    assign rawHazard  = src1Hazard || src2Hazard;

    // load in execute feeding decode
    assign loadUseStall = loadExec && (destRegExec != '0) &&
                          ((destRegExec == sourceReg1Dec) || (destRegExec == sourceReg2Dec));

    // the decode slot is flushed by a taken branch anyway
    assign stall = (rawHazard || loadUseStall) && !pcSrcExec;

    assign stallFetch  = stall;
    assign stallDecode = stall;

    // taken beq kills the two younger instructions
    assign flushDecode = pcSrcExec;
    assign flushExec   = pcSrcExec || stall;

endmodule

/* source/memWriteback.sv */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module memWriteback (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::wordT   aluResultMem,
    input  rvPkg::wordT   storeDataMem,
    input  rvPkg::regIdxT destRegMem,
    input  logic          loadMem,
    input  logic          storeMem,
    input  logic          validMem,
    output logic          storeValid,
    output rvPkg::wordT   storeAddr,
    output rvPkg::wordT   storeData,
    output logic          regWe,
    output rvPkg::regIdxT regWrAddr,
    output rvPkg::wordT   regWrData,
    output logic          retireValid,
    output rvPkg::regIdxT retireRd,
    output rvPkg::wordT   retireData
);
    import rvPkg::*;

    localparam int dmemAddrW = $clog2(`DMEM_WORDS);

    wordT   dmem [`DMEM_WORDS];
    wordT   loadData;
    wordT   resultMem;
    logic   validWb;
    regIdxT destWb;
    wordT   resultWb;

    // sw observed while in the memory stage
    assign storeValid = validMem && storeMem;
    assign storeAddr  = aluResultMem;
    assign storeData  = storeDataMem;

    // word aligned access, byte offset dropped
    always_ff @(posedge clk) begin
        if (storeValid) begin
            dmem[aluResultMem[dmemAddrW+1:2]] <= storeDataMem;
        end
    end

    assign loadData  = dmem[aluResultMem[dmemAddrW+1:2]];
    assign resultMem = loadMem ? loadData : aluResultMem;

    // writeback register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validWb <= 1'b0;
            destWb  <= '0;
        end else begin
            validWb <= validMem;
            destWb  <= destRegMem;
        end
    end

    always_ff @(posedge clk) begin
        resultWb <= resultMem;
    end

    // writes to x0 are dropped and never retire
    assign regWe     = validWb && (destWb != '0);
    assign regWrAddr = destWb;
    assign regWrData = resultWb;

    assign retireValid = regWe;
    assign retireRd    = destWb;
    assign retireData  = resultWb;

endmodule

/* source/regFile.sv */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module regFile (
    input  logic          clk,
    input  logic          rstN,
    input  rvPkg::regIdxT readAddr1,
    input  rvPkg::regIdxT readAddr2,
    input  logic          regWe,
    input  rvPkg::regIdxT regWrAddr,
    input  rvPkg::wordT   regWrData,
    output rvPkg::wordT   readData1,
    output rvPkg::wordT   readData2
);
    import rvPkg::*;

    wordT regs [`REG_COUNT];

    // x0 reads zero, a same-cycle write is bypassed to the reader
    function automatic wordT readPort(input regIdxT addr);
        if (addr == '0) begin
            return '0;
        end else if (regWe && (regWrAddr == addr)) begin
            return regWrData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe && (regWrAddr != '0)) begin
            regs[regWrAddr] <= regWrData;
        end
    end

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

endmodule

/* source/rvCore.sv */
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvCore (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           imemWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr,
    input  rvPkg::wordT                    imemData,
    output logic                           retireValid,
    output rvPkg::regIdxT                  retireRd,
    output rvPkg::wordT                    retireData,
    output logic                           storeValid,
    output rvPkg::wordT                    storeAddr,
    output rvPkg::wordT                    storeData
);
    import rvPkg::*;

    // fetch to decode
    wordT   pcDecode;
    wordT   instrDecode;
    logic   validDecode;

    // decode to register file and hazard unit
    regIdxT sourceReg1Dec;
    regIdxT sourceReg2Dec;
    wordT   readData1;
    wordT   readData2;

    // execute stage fields
    wordT   pcExec;
    wordT   operandAExec;
    wordT   operandBExec;
    wordT   immExec;
    aluOpE  aluOpExec;
    logic   useImmExec;
    regIdxT destRegExec;
    logic   loadExec;
    logic   storeExec;
    logic   branchExec;
    logic   validExec;

    // branch resolution
    logic   pcSrcExec;
    wordT   branchTarget;

    // memory stage fields
    wordT   aluResultMem;
    wordT   storeDataMem;
    regIdxT destRegMem;
    logic   loadMem;
    logic   storeMem;
    logic   validMem;

    // register write from writeback
    logic   regWe;
    regIdxT regWrAddr;
    wordT   regWrData;

    // hazard controls
    logic   stallFetch;
    logic   stallDecode;
    logic   flushDecode;
    logic   flushExec;

    // wire names match the stage ports
    fetchUnit fetchInst (.*);

    decodeUnit decodeInst (.*);

    regFile regFileInst (
        .*,
        .readAddr1 (sourceReg1Dec),
        .readAddr2 (sourceReg2Dec)
    );

    hazardDetect hazardInst (.*);

    executeUnit executeInst (.*);

    memWriteback memWbInst (.*);

endmodule

/* source/rvPkg.sv */
`include "rv_cfg.svh"

package rvPkg;

    // one machine word
    typedef logic [`XLEN-1:0] wordT;

    // register index, 5 bits for 32 registers
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

    // alu functions used by the supported subset
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassB
    } aluOpE;

    // major opcodes, instr[6:0]
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

endpackage

/* source/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path width in bits
`define XLEN 32

// architectural integer registers, x0 included
`define REG_COUNT 32

// instruction memory depth in 32-bit words
`define IMEM_WORDS 64

// data memory depth in 32-bit words
`define DMEM_WORDS 64

`endif
